/* include/pathOramCrypt_config.svh */
/* Path ORAM encryption datapath configuration
   Lane geometry, IV size, mix rounds and path buffer depth */
`ifndef PATH_ORAM_CRYPT_CONFIG_SVH
`define PATH_ORAM_CRYPT_CONFIG_SVH

// Cipher lanes per DRAM burst
`define PORAM_LANES 4

// Bits carried by one lane
`define PORAM_LANE_WIDTH 32

// IV stamped on every written burst
`define PORAM_IV_WIDTH 32

// Mix rounds, one pipeline stage each
`define PORAM_ROUNDS 4

// DRAM read path buffer entries
`define PORAM_PATH_BUFFER_DEPTH 16

`endif

/* rtl/oramDramPkg.sv */
/* DRAM-side and backend-side burst types
   Plaintext bursts toward the backend, IV plus ciphertext toward DRAM */
`default_nettype none

`include "pathOramCrypt_config.svh"

package oramDramPkg;

	// --------------------
	// Lane level
	// --------------------

	// One lane word of a burst
	typedef logic [`PORAM_LANE_WIDTH-1:0] laneWord_t;

	// Counter mode IV
	typedef logic [`PORAM_IV_WIDTH-1:0] iv_t;

	// --------------------
	// Burst level
	// --------------------

	// Backend plaintext burst, lane 0 in the low bits
	typedef laneWord_t [`PORAM_LANES-1:0] burst_t;

	// Word as stored in DRAM
	// IV travels in the top bits, above the ciphertext
	typedef struct packed {
		iv_t iv;
		burst_t payload;
	} dramWord_t;

endpackage

`default_nettype wire

/* rtl/cryptPkg.sv */
/* Cipher job and lane result types
   What the splitter hands to each lane and what a lane returns */
`default_nettype none

`include "pathOramCrypt_config.svh"

package cryptPkg;

	// Which way a burst is going
	typedef enum logic {
		dirWrite = 1'b0,
		dirRead = 1'b1
	} direction_t;

	// --------------------
	// Splitter to lane
	// --------------------

	typedef struct packed {
		direction_t direction;
		oramDramPkg::iv_t iv;
		// Plaintext on writes, ciphertext on reads
		oramDramPkg::laneWord_t data;
	} laneJob_t;

	// One job per lane, issued together
	typedef laneJob_t [`PORAM_LANES-1:0] laneJobs_t;

	// --------------------
	// Lane to merger
	// --------------------

	typedef struct packed {
		direction_t direction;
		oramDramPkg::iv_t iv;
		// Data XOR keystream
		oramDramPkg::laneWord_t data;
	} laneResult_t;

	// All lane results of one burst
	typedef laneResult_t [`PORAM_LANES-1:0] laneResults_t;

endpackage

`default_nettype wire

/* rtl/pathBuffer.sv */
/* Synchronous FIFO with a type parameter for the payload
   Buffers DRAM read words ahead of the decrypt lanes */
`timescale 1ns/1ps
`default_nettype none

module pathBuffer #(
	parameter type payload_t = logic [31:0],
	parameter int Depth = 16
) (
	input wire logic Clock,
	input wire logic reset,
	input wire payload_t inData,
	input wire logic inValid,
	output logic inReady,
	output payload_t outData,
	output logic outValid,
	input wire logic outReady
);

	localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
	localparam int CountWidth = $clog2(Depth + 1);

	payload_t mem [Depth];
	logic [PtrWidth-1:0] wrPtr;
	logic [PtrWidth-1:0] rdPtr;
	logic [CountWidth-1:0] count;
	logic push;
	logic pop;

	// Full buffer still takes a word when the head leaves this cycle
	assign inReady = (count != CountWidth'(Depth)) || outReady;
	assign outValid = (count != '0);
	assign push = inValid && inReady;
	assign pop = outValid && outReady;

	// Head read straight from storage
	assign outData = mem[rdPtr];

	// --------------------
	// Pointers and occupancy
	// --------------------
	always_ff @(posedge Clock) begin
		if (reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push)
				wrPtr <= (wrPtr == PtrWidth'(Depth - 1)) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == PtrWidth'(Depth - 1)) ? '0 : rdPtr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	// Storage write
	always_ff @(posedge Clock) begin
		if (push)
			mem[wrPtr] <= inData;
	end

endmodule

`default_nettype wire

/* rtl/laneSplitter.sv */
/* Lane splitter for the encryption datapath
   Picks a buffered read or a backend write, stamps write IVs,
   and registers one job per cipher lane */
`timescale 1ns/1ps
`default_nettype none

`include "pathOramCrypt_config.svh"

module laneSplitter (
	input wire logic Clock,
	input wire logic reset,

	// Backend write bursts
	input wire oramDramPkg::burst_t writeData,
	input wire logic writeValid,
	output logic writeReady,

	// Buffered DRAM reads
	input wire oramDramPkg::dramWord_t readIn,
	input wire logic readValid,
	output logic readReady,

	// Jobs to the lanes
	output cryptPkg::laneJobs_t jobs,
	output logic jobValid,
	input wire logic [`PORAM_LANES-1:0] jobReady
);

	localparam int Lanes = `PORAM_LANES;

	logic canLoad;
	logic takeRead;
	logic takeWrite;
	oramDramPkg::iv_t writeIv;
	cryptPkg::laneJobs_t nextJobs;

	// Job register free, or every lane takes it this cycle
	assign canLoad = !jobValid || (&jobReady);

	// Reads win when both are pending
	assign readReady = canLoad;
	assign writeReady = canLoad && !readValid;

	assign takeRead = readValid && readReady;
	assign takeWrite = writeValid && writeReady;

	// --------------------
	// Job assembly
	// --------------------
	always_comb begin
		for (int i = 0; i < Lanes; i++) begin
			if (takeRead) begin
				// Decrypt with the IV stored in the word
				nextJobs[i].direction = cryptPkg::dirRead;
				nextJobs[i].iv = readIn.iv;
				nextJobs[i].data = readIn.payload[i];
			end else begin
				// Fresh IV from the write counter
				nextJobs[i].direction = cryptPkg::dirWrite;
				nextJobs[i].iv = writeIv;
				nextJobs[i].data = writeData[i];
			end
		end
	end

	// Job valid and write IV counter
	always_ff @(posedge Clock) begin
		if (reset) begin
			jobValid <= 1'b0;
			// First write gets IV 1
			writeIv <= oramDramPkg::iv_t'(1);
		end else begin
			if (canLoad)
				jobValid <= takeRead || takeWrite;
			if (takeWrite)
				writeIv <= writeIv + 1'b1;
		end
	end

	// Job payload
	always_ff @(posedge Clock) begin
		if (takeRead || takeWrite)
			jobs <= nextJobs;
	end

endmodule

`default_nettype wire

/* rtl/cipherLane.sv */
/* One cipher lane, counter mode over a 32-bit lane word
   Pipelined keyed add-rotate-xor keystream, one round per stage */
`timescale 1ns/1ps
`default_nettype none

`include "pathOramCrypt_config.svh"

module cipherLane #(
	parameter int LaneIndex = 0
) (
	input wire logic Clock,
	input wire logic reset,
	input wire logic [`PORAM_LANE_WIDTH-1:0] key,
	input wire cryptPkg::laneJob_t job,
	input wire logic jobValid,
	output logic jobReady,
	output cryptPkg::laneResult_t result,
	output logic resultValid,
	input wire logic resultReady
);

	localparam int Width = `PORAM_LANE_WIDTH;
	localparam int Stages = `PORAM_ROUNDS;
	// Per lane seed, lane index times the golden ratio constant
	localparam logic [Width-1:0] LaneSeed = Width'(LaneIndex * 32'h9e3779b9);

	logic [Stages-1:0] stageValid;
	logic [Stages-1:0] stageReady;
	cryptPkg::laneJob_t stageJob [Stages];
	logic [Width-1:0] stageState [Stages];
	logic [Width-1:0] nextState [Stages];

	// Rotate left by 5, add round key, XOR IV
	function automatic logic [Width-1:0] mixRound(
		input logic [Width-1:0] state,
		input logic [Width-1:0] iv,
		input logic [Width-1:0] roundKey
	);
		logic [Width-1:0] rotated;
		rotated = {state[Width-6:0], state[Width-1:Width-5]};
		return (rotated + roundKey) ^ iv;
	endfunction

	// --------------------
	// Round logic and stall chain
	// --------------------
	always_comb begin
		nextState[0] = mixRound(key ^ job.iv ^ LaneSeed, job.iv, key);
		for (int k = 1; k < Stages; k++)
			nextState[k] = mixRound(stageState[k - 1], stageJob[k - 1].iv, key + Width'(k));

		// Stage moves when empty or when the one after it moves
		stageReady[Stages - 1] = !stageValid[Stages - 1] || resultReady;
		for (int k = Stages - 2; k >= 0; k--)
			stageReady[k] = !stageValid[k] || stageReady[k + 1];
	end

	// Stage valid bits
	always_ff @(posedge Clock) begin
		if (reset) begin
			stageValid <= '0;
		end else begin
			if (stageReady[0])
				stageValid[0] <= jobValid;
			for (int k = 1; k < Stages; k++)
				if (stageReady[k])
					stageValid[k] <= stageValid[k - 1];
		end
	end

	// Stage payload, job carried alongside its state
	always_ff @(posedge Clock) begin
		if (stageReady[0] && jobValid) begin
			stageJob[0] <= job;
			stageState[0] <= nextState[0];
		end
		for (int k = 1; k < Stages; k++) begin
			if (stageReady[k] && stageValid[k - 1]) begin
				stageJob[k] <= stageJob[k - 1];
				stageState[k] <= nextState[k];
			end
		end
	end

	assign jobReady = stageReady[0];
	assign resultValid = stageValid[Stages - 1];

	// Last stage, keystream applied to the data
	always_comb begin
		result.direction = stageJob[Stages - 1].direction;
		result.iv = stageJob[Stages - 1].iv;
		result.data = stageJob[Stages - 1].data ^ stageState[Stages - 1];
	end

endmodule

`default_nettype wire

/* rtl/laneMerger.sv */
/* Lane merger for the encryption datapath
   Rebuilds a burst from all lane results and routes it to
   the DRAM write port or the backend read port */
`timescale 1ns/1ps
`default_nettype none

`include "pathOramCrypt_config.svh"

module laneMerger (
	input wire logic Clock,
	input wire logic reset,

	// Lane results
	input wire cryptPkg::laneResults_t results,
	input wire logic [`PORAM_LANES-1:0] resultValid,
	output logic resultReady,

	// Encrypted words to DRAM
	output oramDramPkg::dramWord_t dramWriteData,
	output logic dramWriteValid,
	input wire logic dramWriteReady,

	// Decrypted bursts to the backend
	output oramDramPkg::burst_t readData,
	output logic readValid,
	input wire logic readReady
);

	localparam int Lanes = `PORAM_LANES;

	logic allValid;
	logic isWrite;
	logic writeSlotFree;
	logic readSlotFree;
	logic loadWrite;
	logic loadRead;
	oramDramPkg::burst_t merged;

	// Lanes run in lock step, lane 0 speaks for the burst
	assign allValid = &resultValid;
	assign isWrite = (results[0].direction == cryptPkg::dirWrite);

	// Output register empty or draining this cycle
	assign writeSlotFree = !dramWriteValid || dramWriteReady;
	assign readSlotFree = !readValid || readReady;

	assign resultReady = allValid && (isWrite ? writeSlotFree : readSlotFree);
	assign loadWrite = resultReady && isWrite;
	assign loadRead = resultReady && !isWrite;

	always_comb begin
		for (int i = 0; i < Lanes; i++)
			merged[i] = results[i].data;
	end

	// --------------------
	// Output valids
	// --------------------
	always_ff @(posedge Clock) begin
		if (reset) begin
			dramWriteValid <= 1'b0;
			readValid <= 1'b0;
		end else begin
			if (loadWrite)
				dramWriteValid <= 1'b1;
			else if (dramWriteReady)
				dramWriteValid <= 1'b0;

			if (loadRead)
				readValid <= 1'b1;
			else if (readReady)
				readValid <= 1'b0;
		end
	end

	// Output data, IV goes out with the ciphertext
	always_ff @(posedge Clock) begin
		if (loadWrite) begin
			dramWriteData.iv <= results[0].iv;
			dramWriteData.payload <= merged;
		end
		if (loadRead)
			readData <= merged;
	end

endmodule

`default_nettype wire

/* rtl/pathOramCrypt.sv */
/* DRAM-side encryption datapath of a Path ORAM controller
   Path buffer, lane splitter, cipher lanes and lane merger */
`timescale 1ns/1ps
`default_nettype none

`include "pathOramCrypt_config.svh"

module pathOramCrypt (
	input wire logic Clock,
	input wire logic reset,
	input wire logic [`PORAM_LANE_WIDTH-1:0] key,

	// Backend writes
	input wire oramDramPkg::burst_t writeData,
	input wire logic writeValid,
	output logic writeReady,

	// DRAM write
	output oramDramPkg::dramWord_t dramWriteData,
	output logic dramWriteValid,
	input wire logic dramWriteReady,

	// DRAM read, source must honor dramReadReady
	input wire oramDramPkg::dramWord_t dramReadData,
	input wire logic dramReadValid,
	output logic dramReadReady,

	// Backend reads
	output oramDramPkg::burst_t readData,
	output logic readValid,
	input wire logic readReady
);

	localparam int Lanes = `PORAM_LANES;

	// Path buffer to splitter
	oramDramPkg::dramWord_t bufData;
	logic bufValid;
	logic bufReady;

	// Splitter to lanes
	cryptPkg::laneJobs_t jobs;
	logic jobValid;
	logic [Lanes-1:0] jobReady;

	// Lanes to merger
	cryptPkg::laneResults_t results;
	logic [Lanes-1:0] resultValid;
	logic resultReady;

	// --------------------
	// DRAM read buffer
	// --------------------
	pathBuffer #(
		.payload_t(oramDramPkg::dramWord_t),
		.Depth(`PORAM_PATH_BUFFER_DEPTH)
	) pathBuf (
		.Clock(Clock),
		.reset(reset),
		.inData(dramReadData),
		.inValid(dramReadValid),
		.inReady(dramReadReady),
		.outData(bufData),
		.outValid(bufValid),
		.outReady(bufReady)
	);

	laneSplitter splitter (
		.Clock(Clock),
		.reset(reset),
		.writeData(writeData),
		.writeValid(writeValid),
		.writeReady(writeReady),
		.readIn(bufData),
		.readValid(bufValid),
		.readReady(bufReady),
		.jobs(jobs),
		.jobValid(jobValid),
		.jobReady(jobReady)
	);

	// --------------------
	// Cipher lanes
	// --------------------
	for (genvar i = 0; i < Lanes; i++) begin : lane
		cipherLane #(
			.LaneIndex(i)
		) cipher (
			.Clock(Clock),
			.reset(reset),
			.key(key),
			.job(jobs[i]),
			.jobValid(jobValid),
			.jobReady(jobReady[i]),
			.result(results[i]),
			.resultValid(resultValid[i]),
			.resultReady(resultReady)
		);
	end

	laneMerger merger (
		.Clock(Clock),
		.reset(reset),
		.results(results),
		.resultValid(resultValid),
		.resultReady(resultReady),
		.dramWriteData(dramWriteData),
		.dramWriteValid(dramWriteValid),
		.dramWriteReady(dramWriteReady),
		.readData(readData),
		.readValid(readValid),
		.readReady(readReady)
	);

endmodule

`default_nettype wire

/* testbench/tbClock.sv */
/* Testbench clock source
   Free-running clock, low at time zero */
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
	parameter int PeriodNs = 4
) (
	output logic Clock
);

	// Half period high, half low
	initial begin
		Clock = 1'b0;
		forever #(PeriodNs / 2) Clock = ~Clock;
	end

endmodule

`default_nettype wire

/* testbench/pathOramCrypt_checker.sv */
/* Handshake checker for the encryption datapath
   Output hold rules, reset state and DRAM read flow control */
`timescale 1ns/1ps
`default_nettype none

module pathOramCrypt_checker (
	input wire logic Clock,
	input wire logic reset,
	input wire oramDramPkg::dramWord_t dramWriteData,
	input wire logic dramWriteValid,
	input wire logic dramWriteReady,
	input wire oramDramPkg::burst_t readData,
	input wire logic readValid,
	input wire logic readReady,
	input wire logic dramReadValid,
	input wire logic dramReadReady
);

	// Failed assertion count
	int errorCount = 0;

	// --------------------
	// Output hold rules
	// --------------------

	// DRAM word stays put until DRAM takes it
	assert property (@(posedge Clock) disable iff (reset)
		dramWriteValid && !dramWriteReady |=> dramWriteValid && $stable(dramWriteData))
	else begin
		errorCount++;
		$error("DRAM write word dropped or changed before it was accepted");
	end

	// Same for the backend read burst
	assert property (@(posedge Clock) disable iff (reset)
		readValid && !readReady |=> readValid && $stable(readData))
	else begin
		errorCount++;
		$error("Backend read burst dropped or changed before it was accepted");
	end

	// Both output registers come up empty
	assert property (@(posedge Clock) reset |=> !dramWriteValid && !readValid)
	else begin
		errorCount++;
		$error("An output valid was high right after reset");
	end

	// --------------------
	// DRAM read side
	// --------------------

	// No ready input on the DRAM side so the source watches dramReadReady
	assert property (@(posedge Clock) disable iff (reset)
		dramReadValid |-> dramReadReady)
	else begin
		errorCount++;
		$error("DRAM read word arrived while the path buffer was full");
	end

endmodule

bind pathOramCrypt pathOramCrypt_checker handshakeCheck (
	.Clock(Clock),
	.reset(reset),
	.dramWriteData(dramWriteData),
	.dramWriteValid(dramWriteValid),
	.dramWriteReady(dramWriteReady),
	.readData(readData),
	.readValid(readValid),
	.readReady(readReady),
	.dramReadValid(dramReadValid),
	.dramReadReady(dramReadReady)
);

`default_nettype wire

/* testbench/pathOramCrypt_tb.sv */
/* Testbench for the Path ORAM encryption datapath
   Random bursts both ways checked against a counter mode model */
`timescale 1ns/1ps
`default_nettype none

`include "pathOramCrypt_config.svh"

module pathOramCrypt_tb;

	localparam int Lanes = `PORAM_LANES;
	localparam int Timeout = 400;
	// Reads kept in flight stay below the buffer depth so it never fills
	localparam int ReadWindow = `PORAM_PATH_BUFFER_DEPTH;
	// Buffer plus splitter, four lane stages and merger
	localparam int ReadCapacity = `PORAM_PATH_BUFFER_DEPTH + 6;

	logic Clock;
	logic reset;
	logic [31:0] key;
	oramDramPkg::burst_t writeData;
	logic writeValid;
	logic writeReady;
	oramDramPkg::dramWord_t dramWriteData;
	logic dramWriteValid;
	logic dramWriteReady;
	oramDramPkg::dramWord_t dramReadData;
	logic dramReadValid;
	logic dramReadReady;
	oramDramPkg::burst_t readData;
	logic readValid;
	logic readReady;

	// Model state
	logic [31:0] lfsrState;
	oramDramPkg::iv_t modelIv;
	oramDramPkg::dramWord_t expWrite [$];
	oramDramPkg::burst_t expRead [$];
	oramDramPkg::dramWord_t captured [$];
	oramDramPkg::dramWord_t replay [$];
	oramDramPkg::burst_t plainHistory [$];
	logic randomReady;
	logic loopback;

	tbClock #(.PeriodNs(4)) clockGen (.Clock(Clock));

	pathOramCrypt uut (
		.Clock(Clock),
		.reset(reset),
		.key(key),
		.writeData(writeData),
		.writeValid(writeValid),
		.writeReady(writeReady),
		.dramWriteData(dramWriteData),
		.dramWriteValid(dramWriteValid),
		.dramWriteReady(dramWriteReady),
		.dramReadData(dramReadData),
		.dramReadValid(dramReadValid),
		.dramReadReady(dramReadReady),
		.readData(readData),
		.readValid(readValid),
		.readReady(readReady)
	);

	// --------------------
	// Random source and model
	// --------------------

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	// Keyed add-rotate-xor mix for one lane
	function automatic logic [31:0] keystream(input logic [31:0] k, input logic [31:0] iv,
		input int lane);
		logic [31:0] s;
		s = k ^ iv ^ (32'(lane) * 32'h9e3779b9);
		for (int r = 0; r < 4; r++) begin
			s = (s << 5) | (s >> 27);
			s = s + k + 32'(r);
			s = s ^ iv;
		end
		return s;
	endfunction

	// Encrypt and decrypt are the same XOR
	function automatic oramDramPkg::burst_t applyKeystream(input oramDramPkg::burst_t data,
		input logic [31:0] iv);
		oramDramPkg::burst_t out;
		for (int i = 0; i < Lanes; i++)
			out[i] = data[i] ^ keystream(key, iv, i);
		return out;
	endfunction

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1, "Run stopped at the first failure");
	endtask

	// One LFSR step per bit with the new bit shifted in at the bottom
	task automatic drawBits(input int count, output logic [31:0] bits);
		bits = '0;
		for (int n = 0; n < count; n++) begin
			lfsrState = lfsrStep(lfsrState);
			bits = {bits[30:0], lfsrState[0]};
		end
	endtask

	task automatic randomBurst(output oramDramPkg::burst_t b);
		for (int i = 0; i < Lanes; i++)
			drawBits(32, b[i]);
	endtask

	task automatic randomWord(output oramDramPkg::dramWord_t w);
		drawBits(32, w.iv);
		randomBurst(w.payload);
	endtask

	// --------------------
	// Cycle step
	// --------------------

	// Sample at the falling edge and drive 1 ns after the rising edge
	task automatic stepCycle();
		logic writeTaken;
		logic readTaken;
		logic [31:0] bits;
		@(negedge Clock);
		assert (uut.handshakeCheck.errorCount == 0)
		else abortRun("The bound handshake checker saw a broken handshake rule");
		writeTaken = writeValid && writeReady;
		readTaken = dramReadValid && dramReadReady;
		if (dramReadValid)
			assert (dramReadReady)
			else abortRun("DRAM read word was offered while the path buffer was full");
		if (writeTaken) begin
			expWrite.push_back(oramDramPkg::dramWord_t'({modelIv,
				applyKeystream(writeData, modelIv)}));
			plainHistory.push_back(writeData);
			modelIv++;
		end
		if (readTaken) begin
			// Replayed words must come back as the original plaintext
			if (loopback)
				expRead.push_back(plainHistory.pop_front());
			else
				expRead.push_back(applyKeystream(dramReadData.payload, dramReadData.iv));
		end
		if (dramWriteValid && dramWriteReady) begin
			assert (expWrite.size() > 0)
			else abortRun("A DRAM write came out with no write burst outstanding");
			assert (dramWriteData === expWrite[0])
			else abortRun($sformatf("[ERROR] %0t DRAM write %h, expected %h",
				$time, dramWriteData, expWrite[0]));
			captured.push_back(dramWriteData);
			void'(expWrite.pop_front());
		end
		if (readValid && readReady) begin
			assert (expRead.size() > 0)
			else abortRun("A backend read came out with no read word outstanding");
			assert (readData === expRead[0])
			else abortRun($sformatf("[ERROR] %0t read data %h, expected %h",
				$time, readData, expRead[0]));
			void'(expRead.pop_front());
		end
		@(posedge Clock);
		#1;
		if (writeTaken)
			writeValid = 1'b0;
		if (readTaken)
			dramReadValid = 1'b0;
		// Ready high three cycles in four
		if (randomReady) begin
			drawBits(4, bits);
			dramWriteReady = bits[0] | bits[1];
			readReady = bits[2] | bits[3];
		end
	endtask

	task automatic sendWrite();
		int guard;
		guard = 0;
		randomBurst(writeData);
		writeValid = 1'b1;
		while (writeValid) begin
			guard++;
			if (guard > Timeout)
				abortRun("A write burst was never accepted");
			stepCycle();
		end
	endtask

	task automatic sendRead(input oramDramPkg::dramWord_t word);
		int guard;
		guard = 0;
		while (expRead.size() >= ReadWindow) begin
			guard++;
			if (guard > Timeout)
				abortRun("Outstanding reads never drained");
			stepCycle();
		end
		dramReadData = word;
		dramReadValid = 1'b1;
		while (dramReadValid) begin
			guard++;
			if (guard > Timeout)
				abortRun("A DRAM read word was never accepted");
			stepCycle();
		end
	endtask

	task automatic drain();
		int guard;
		guard = 0;
		while (expWrite.size() != 0 || expRead.size() != 0) begin
			guard++;
			if (guard > Timeout)
				abortRun("Expected outputs never appeared");
			stepCycle();
		end
	endtask

	// --------------------
	// Test sequence
	// --------------------
	initial begin
		logic [31:0] bits;
		int guard;
		int writesLeft;
		int readsLeft;
		oramDramPkg::dramWord_t word;

		reset = 1'b1;
		key = '0;
		writeData = '0;
		writeValid = 1'b0;
		dramWriteReady = 1'b1;
		dramReadData = '0;
		dramReadValid = 1'b0;
		readReady = 1'b1;
		lfsrState = 32'hcef6;
		modelIv = 1;
		randomReady = 1'b0;
		loopback = 1'b0;
		drawBits(32, key);

		repeat (2) @(posedge Clock);
		#1;
		reset = 1'b0;

		// Idle state after reset
		assert (!dramWriteValid && !readValid && writeReady && dramReadReady)
		else abortRun($sformatf("[ERROR] %0t wrong idle handshake outputs after reset", $time));

		// Encrypt with IVs counting from 1
		repeat (12) sendWrite();
		drain();

		// Decrypt random DRAM words
		repeat (16) begin
			randomWord(word);
			sendRead(word);
		end
		drain();

		// Captured writes fed back as reads
		replay = captured;
		loopback = 1'b1;
		while (replay.size() != 0)
			sendRead(replay.pop_front());
		drain();
		loopback = 1'b0;

		// Mixed traffic under random back-pressure
		randomReady = 1'b1;
		writesLeft = 24;
		readsLeft = 24;
		guard = 0;
		while (writesLeft > 0 || readsLeft > 0 || writeValid || dramReadValid) begin
			guard++;
			if (guard > Timeout)
				abortRun("Mixed traffic stalled");
			drawBits(2, bits);
			if (!writeValid && writesLeft > 0 && bits[0]) begin
				randomBurst(writeData);
				writeValid = 1'b1;
				writesLeft--;
			end
			if (!dramReadValid && readsLeft > 0 && bits[1] && expRead.size() < ReadWindow) begin
				randomWord(dramReadData);
				dramReadValid = 1'b1;
				readsLeft--;
			end
			stepCycle();
		end
		randomReady = 1'b0;
		dramWriteReady = 1'b1;
		readReady = 1'b1;
		drain();

		// Fill the read path with the backend stalled
		readReady = 1'b0;
		stepCycle();
		guard = 0;
		while (dramReadReady) begin
			guard++;
			if (guard > Timeout)
				abortRun("Path buffer never reported full with reads stalled");
			randomWord(dramReadData);
			dramReadValid = 1'b1;
			stepCycle();
		end
		assert (expRead.size() <= ReadCapacity)
		else abortRun($sformatf("[ERROR] %0t read path took %0d words, limit %0d",
			$time, expRead.size(), ReadCapacity));
		readReady = 1'b1;
		drain();

		if (expWrite.size() == 0 && expRead.size() == 0
			&& uut.handshakeCheck.errorCount == 0) begin
			$display("Simulation passed");
			$finish;
		end else
			abortRun("Outputs were still pending or a handshake rule broke by the end of the run");
	end

endmodule

`default_nettype wire

/* pathOramCrypt.f */
+incdir+include
rtl/oramDramPkg.sv
rtl/cryptPkg.sv
rtl/pathBuffer.sv
rtl/laneSplitter.sv
rtl/cipherLane.sv
rtl/laneMerger.sv
rtl/pathOramCrypt.sv
testbench/tbClock.sv
testbench/pathOramCrypt_checker.sv
testbench/pathOramCrypt_tb.sv
